// ==== logic/ex_ft_pkg.sv ====
// Shared definitions for the fault-tolerant execute stage
// Widths, ALU operations, request kinds and the packed structs
// carried between decode, execute and result
package ex_ft_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;
  localparam int NUM_LANES  = 3;

  // Reduced ALU operation set
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLT  = 4'd7,
    ALU_SLTU = 4'd8,
    ALU_EQ   = 4'd9,
    ALU_NE   = 4'd10
  } alu_op_e;

  // Which unit owns the request in EX
  typedef enum logic [2:0] {
    KIND_NOP    = 3'd0,
    KIND_ALU    = 3'd1,
    KIND_CSR    = 3'd2,
    KIND_LSU    = 3'd3,
    KIND_BRANCH = 3'd4
  } req_kind_e;

  ////////////////////////////////////////////////////////////
  // Lane payloads
  ////////////////////////////////////////////////////////////

  // Control fields, voted across lanes
  typedef struct packed {
    req_kind_e               kind;
    logic                    fw_we;
    logic [REG_ADDR_W-1:0]   fw_addr;
    logic                    lsu_we;
    logic [REG_ADDR_W-1:0]   lsu_addr;
  } ex_ctrl_t;

  // Operands, kept per lane so each replica computes on its own copy
  typedef struct packed {
    alu_op_e                 op;
    logic [XLEN-1:0]         op_a;
    logic [XLEN-1:0]         op_b;
    logic [XLEN-1:0]         op_c;
  } ex_lane_t;

  typedef struct packed {
    ex_ctrl_t                ctrl;
    ex_lane_t                lane;
  } ex_req_t;

  typedef struct packed {
    logic [XLEN-1:0]         result;
    logic                    cmp;
  } alu_out_t;

  // Register file write
  typedef struct packed {
    logic                    we;
    logic [REG_ADDR_W-1:0]   addr;
    logic [XLEN-1:0]         data;
  } wb_port_t;

  typedef struct packed {
    logic                    detected;
    logic                    corrected;
  } ft_flags_t;

endpackage

// ==== logic/ft_majority_voter.sv ====
// Three-way majority voter
// Bitwise vote over any packed payload, with per-lane mismatch bits
// and detected/corrected flags
`timescale 1ns/1ns

module ft_majority_voter import ex_ft_pkg::*; #(
  parameter type T = logic [7:0]
) (
  input  T [NUM_LANES-1:0]   lanes_i,
  output T                   voted_o,
  output ft_flags_t          flags_o,
  output logic [NUM_LANES-1:0] lane_err_o
);

  // Bit is set where at least two lanes agree on a one
  assign voted_o = T'((lanes_i[0] & lanes_i[1])
                    | (lanes_i[0] & lanes_i[2])
                    | (lanes_i[1] & lanes_i[2]));

  // Lane disagrees with the vote anywhere in the payload
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_err
    assign lane_err_o[i] = (lanes_i[i] != voted_o);
  end

  // Any mismatch is a detection
  assign flags_o.detected  = |lane_err_o;
  // Single bad lane means the vote masked it
  assign flags_o.corrected = $onehot(lane_err_o);

endmodule

// ==== logic/ex_alu.sv ====
// Single replica ALU
// Arithmetic, logic, shifts, set-less-than and equality compares
// on operands a and b
`timescale 1ns/1ns

module ex_alu import ex_ft_pkg::*; (
  input  ex_lane_t lane_i,
  output alu_out_t out_o
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            equal;

  assign op_a  = lane_i.op_a;
  assign op_b  = lane_i.op_b;
  // Shift amount from the low five bits, RV32 style
  assign shamt = lane_i.op_b[4:0];

  // Shared comparators
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;
  assign equal       = (op_a == op_b);

  always_comb begin
    out_o.result = '0;
    out_o.cmp    = 1'b0;
    case (lane_i.op)
      ALU_ADD:  out_o.result = op_a + op_b;
      ALU_SUB:  out_o.result = op_a - op_b;
      ALU_AND:  out_o.result = op_a & op_b;
      ALU_OR:   out_o.result = op_a | op_b;
      ALU_XOR:  out_o.result = op_a ^ op_b;
      ALU_SLL:  out_o.result = op_a << shamt;
      ALU_SRL:  out_o.result = op_a >> shamt;
      ALU_SLT: begin
        out_o.result = {{(XLEN-1){1'b0}}, lt_signed};
        out_o.cmp    = lt_signed;
      end
      ALU_SLTU: begin
        out_o.result = {{(XLEN-1){1'b0}}, lt_unsigned};
        out_o.cmp    = lt_unsigned;
      end
      // Branch compares only drive the comparison bit
      ALU_EQ:   out_o.cmp = equal;
      ALU_NE:   out_o.cmp = ~equal;
      default: ;
    endcase
  end

endmodule

// ==== logic/ex_decode.sv ====
// Decode front of the execute stage
// Votes the replicated control fields and turns the voted kind into
// unit enables; operands pass on per lane without voting
`timescale 1ns/1ns

module ex_decode import ex_ft_pkg::*; (
  input  ex_req_t  [NUM_LANES-1:0] req_i,
  output ex_ctrl_t                 ctrl_o,
  output ex_lane_t [NUM_LANES-1:0] lanes_o,
  output logic                     alu_en_o,
  output logic                     csr_en_o,
  output logic                     lsu_en_o,
  output logic                     branch_o,
  output ft_flags_t                ctrl_flags_o
);

  ex_ctrl_t [NUM_LANES-1:0] ctrl_lanes;

  // Split each lane into its control and operand halves
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_split
    assign ctrl_lanes[i] = req_i[i].ctrl;
    assign lanes_o[i]    = req_i[i].lane;
  end

  ////////////////////////////////////////////////////////////
  // Control vote
  ////////////////////////////////////////////////////////////

  ft_majority_voter #(
    .T (ex_ctrl_t)
  ) i_ctrl_voter (
    .lanes_i    (ctrl_lanes),
    .voted_o    (ctrl_o),
    .flags_o    (ctrl_flags_o),
    .lane_err_o ()
  );

  // One-hot unit enables from the voted kind
  always_comb begin
    alu_en_o = 1'b0;
    csr_en_o = 1'b0;
    lsu_en_o = 1'b0;
    branch_o = 1'b0;
    case (ctrl_o.kind)
      KIND_ALU:    alu_en_o = 1'b1;
      KIND_CSR:    csr_en_o = 1'b1;
      KIND_LSU:    lsu_en_o = 1'b1;
      KIND_BRANCH: branch_o = 1'b1;
      // NOP and unused codes enable nothing
      default: ;
    endcase
  end

endmodule

// ==== logic/ex_execute.sv ====
// Replicated execute core
// Three ALU replicas with a voted result, the jump target and a
// saturating fault counter per lane that flags permanent faults
`timescale 1ns/1ns

module ex_execute import ex_ft_pkg::*; #(
  parameter int unsigned PERM_FAULT_THRESHOLD = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ex_lane_t [NUM_LANES-1:0] lanes_i,
  input  logic                     check_en_i,
  output alu_out_t                 alu_o,
  output logic [XLEN-1:0]          jump_target_o,
  output ft_flags_t                alu_flags_o,
  output logic [NUM_LANES-1:0]     perm_faulty_o,
  output logic [NUM_LANES-1:0]     perf_faulty_o
);

  localparam int CNT_W = $clog2(PERM_FAULT_THRESHOLD + 1);

  alu_out_t [NUM_LANES-1:0] alu_lanes;
  logic     [NUM_LANES-1:0] lane_err;

  ////////////////////////////////////////////////////////////
  // Replicas and result vote
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_alu
    ex_alu i_ex_alu (
      .lane_i (lanes_i[i]),
      .out_o  (alu_lanes[i])
    );
  end

  ft_majority_voter #(
    .T (alu_out_t)
  ) i_alu_voter (
    .lanes_i    (alu_lanes),
    .voted_o    (alu_o),
    .flags_o    (alu_flags_o),
    .lane_err_o (lane_err)
  );

  // Jump target as bitwise majority, equal to lane 0 when all lanes agree
  assign jump_target_o = (lanes_i[0].op_c & lanes_i[1].op_c)
                       | (lanes_i[0].op_c & lanes_i[2].op_c)
                       | (lanes_i[1].op_c & lanes_i[2].op_c);

  ////////////////////////////////////////////////////////////
  // Permanent fault tracking
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_fault
    logic [CNT_W-1:0] fault_cnt;
    logic             count_up;
    logic             hit_limit;

    // Count only while a real compute is checked, stop at the threshold
    assign count_up  = check_en_i && lane_err[i]
                    && (fault_cnt != CNT_W'(PERM_FAULT_THRESHOLD));
    // This increment brings the count to the threshold
    assign hit_limit = count_up && (fault_cnt == CNT_W'(PERM_FAULT_THRESHOLD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        fault_cnt        <= '0;
        perm_faulty_o[i] <= 1'b0;
        perf_faulty_o[i] <= 1'b0;
      end else begin
        if (count_up) begin
          fault_cnt <= fault_cnt + 1'b1;
        end
        // Sticky once set
        if (hit_limit) begin
          perm_faulty_o[i] <= 1'b1;
        end
        // Single-cycle pulse for the perf counter
        perf_faulty_o[i] <= hit_limit;
      end
    end
  end

endmodule

// ==== logic/ex_result.sv ====
// Result side of the execute stage
// Forwarding write port, EX/WB register for the LSU write port
// and the ready/valid stage handshake
`timescale 1ns/1ns

module ex_result import ex_ft_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_ctrl_t        ctrl_i,
  input  logic            alu_en_i,
  input  logic            csr_en_i,
  input  logic            lsu_en_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] lsu_rdata_i,
  input  logic            lsu_ready_i,
  input  logic            lsu_err_i,
  input  logic            wb_ready_i,
  output wb_port_t        fw_o,
  output wb_port_t        wb_o,
  output logic            ex_ready_o,
  output logic            ex_valid_o
);

  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_addr_q;
  logic                  lsu_we_d;
  logic                  finish;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    fw_o.we   = ctrl_i.fw_we;
    fw_o.addr = ctrl_i.fw_addr;
    // CSR read wins over the ALU result
    if (csr_en_i) begin
      fw_o.data = csr_rdata_i;
    end else if (alu_en_i) begin
      fw_o.data = alu_result_i;
    end else begin
      fw_o.data = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register and LSU port
  ////////////////////////////////////////////////////////////

  // A faulting load never writes the register file
  assign lsu_we_d = ctrl_i.lsu_we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q   <= 1'b0;
      lsu_addr_q <= '0;
    end else if (ex_valid_o) begin
      // wb_ready_i is already part of ex_valid_o
      lsu_we_q <= lsu_we_d;
      if (lsu_we_d) begin
        lsu_addr_q <= ctrl_i.lsu_addr;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrives, drain the stale write
      lsu_we_q <= 1'b0;
    end
  end

  assign wb_o.we   = lsu_we_q;
  assign wb_o.addr = lsu_addr_q;
  // Load data arrives from the LSU in the WB cycle
  assign wb_o.data = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Requests that hand something on to WB
  assign finish     = alu_en_i | csr_en_i | lsu_en_i;
  assign ex_valid_o = finish & lsu_ready_i & wb_ready_i;
  // Branches retire in EX, so they never wait on WB
  assign ex_ready_o = (lsu_ready_i & wb_ready_i) | branch_i;

endmodule

// ==== logic/ex_stage_ft.sv ====
// Fault-tolerant execute stage, top level
// Triplicated decode requests are voted, executed on three ALU
// replicas and written back through the forwarding and LSU ports
`timescale 1ns/1ns

module ex_stage_ft import ex_ft_pkg::*; #(
  parameter int unsigned PERM_FAULT_THRESHOLD = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_req_t [NUM_LANES-1:0] req_i,
  input  logic [XLEN-1:0]         csr_rdata_i,
  input  logic [XLEN-1:0]         lsu_rdata_i,
  input  logic                    lsu_ready_i,
  input  logic                    lsu_err_i,
  input  logic                    wb_ready_i,
  output wb_port_t                fw_o,
  output wb_port_t                wb_o,
  output logic                    branch_decision_o,
  output logic [XLEN-1:0]         jump_target_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o,
  output ft_flags_t               ctrl_flags_o,
  output ft_flags_t               alu_flags_o,
  output logic [NUM_LANES-1:0]    perm_faulty_o,
  output logic [NUM_LANES-1:0]    perf_faulty_o
);

  ex_ctrl_t                 ctrl;
  ex_lane_t [NUM_LANES-1:0] lanes;
  alu_out_t                 alu_out;
  logic                     alu_en;
  logic                     csr_en;
  logic                     lsu_en;
  logic                     branch;
  logic                     check_en;

  ex_decode i_ex_decode (
    .req_i        (req_i),
    .ctrl_o       (ctrl),
    .lanes_o      (lanes),
    .alu_en_o     (alu_en),
    .csr_en_o     (csr_en),
    .lsu_en_o     (lsu_en),
    .branch_o     (branch),
    .ctrl_flags_o (ctrl_flags_o)
  );

  // Lane mismatches only count when the ALU result is consumed
  assign check_en = alu_en | branch;

  ex_execute #(
    .PERM_FAULT_THRESHOLD (PERM_FAULT_THRESHOLD)
  ) i_ex_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .lanes_i       (lanes),
    .check_en_i    (check_en),
    .alu_o         (alu_out),
    .jump_target_o (jump_target_o),
    .alu_flags_o   (alu_flags_o),
    .perm_faulty_o (perm_faulty_o),
    .perf_faulty_o (perf_faulty_o)
  );

  // Voted compare bit decides the branch
  assign branch_decision_o = alu_out.cmp;

  ex_result i_ex_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .alu_en_i     (alu_en),
    .csr_en_i     (csr_en),
    .lsu_en_i     (lsu_en),
    .branch_i     (branch),
    .alu_result_i (alu_out.result),
    .csr_rdata_i  (csr_rdata_i),
    .lsu_rdata_i  (lsu_rdata_i),
    .lsu_ready_i  (lsu_ready_i),
    .lsu_err_i    (lsu_err_i),
    .wb_ready_i   (wb_ready_i),
    .fw_o         (fw_o),
    .wb_o         (wb_o),
    .ex_ready_o   (ex_ready_o),
    .ex_valid_o   (ex_valid_o)
  );

endmodule

// ==== tb/tb_ex_stage_ft.sv ====
// Testbench for the fault-tolerant execute stage
// LFSR driven requests with single and double lane fault injection,
// checked every cycle against a model of the vote, ports and counters
`timescale 1ns/1ns

module tb_ex_stage_ft import ex_ft_pkg::*; ();

  localparam int THRESHOLD  = 4;
  localparam int WAIT_LIMIT = 64;
  localparam int N_ITER     = 40;

  logic                    clk = 1'b0;
  logic                    rst_n;
  ex_req_t [NUM_LANES-1:0] req;
  logic [XLEN-1:0]         csr_rdata;
  logic [XLEN-1:0]         lsu_rdata;
  logic                    lsu_ready;
  logic                    lsu_err;
  logic                    wb_ready;

  wb_port_t                fw;
  wb_port_t                wb;
  logic                    branch_decision;
  logic [XLEN-1:0]         jump_target;
  logic                    ex_ready;
  logic                    ex_valid;
  ft_flags_t               ctrl_flags;
  ft_flags_t               alu_flags;
  logic [NUM_LANES-1:0]    perm_faulty;
  logic [NUM_LANES-1:0]    perf_faulty;

  // Inputs for the next cycle, applied on the rising edge
  ex_req_t [NUM_LANES-1:0] nxt_req;
  logic [XLEN-1:0]         nxt_csr;
  logic [XLEN-1:0]         nxt_rdata;
  logic                    nxt_lsu_ready;
  logic                    nxt_lsu_err;
  logic                    nxt_wb_ready;

  // Model outputs, combinational part
  ex_ctrl_t                exp_ctrl;
  alu_out_t                exp_alu;
  logic [NUM_LANES-1:0]    exp_alu_err;
  ft_flags_t               exp_ctrl_flags;
  ft_flags_t               exp_alu_flags;
  wb_port_t                exp_fw;
  logic [XLEN-1:0]         exp_jt;
  logic                    exp_valid;
  logic                    exp_ready;
  // Model state
  logic                    exp_wb_we;
  logic [REG_ADDR_W-1:0]   exp_wb_addr;
  int                      fault_cnt [NUM_LANES];
  logic [NUM_LANES-1:0]    exp_perm;
  logic [NUM_LANES-1:0]    exp_perf;

  string                   test_name;
  int                      checks;
  int                      test_errors;
  int                      tests_run;
  int                      tests_failed;
  logic [31:0]             lfsr = 32'h747a_e19a;

  always #50 clk = ~clk;

  ex_stage_ft #(
    .PERM_FAULT_THRESHOLD (THRESHOLD)
  ) i_ex_stage_ft (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_i       (lsu_ready),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .fw_o              (fw),
    .wb_o              (wb),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .ctrl_flags_o      (ctrl_flags),
    .alu_flags_o       (alu_flags),
    .perm_faulty_o     (perm_faulty),
    .perf_faulty_o     (perf_faulty)
  );

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////

  // One Galois step per bit, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Ops whose result always changes when operand a changes
  function automatic alu_op_e pick_arith();
    logic [1:0] sel;
    sel = 2'(rand_bits(2) % 3);
    case (sel)
      2'd0:    return ALU_ADD;
      2'd1:    return ALU_SUB;
      default: return ALU_XOR;
    endcase
  endfunction

  function automatic ex_req_t rand_req(input req_kind_e kind);
    ex_req_t r;
    r.ctrl.kind     = kind;
    r.ctrl.fw_we    = 1'(rand_bits(1));
    r.ctrl.fw_addr  = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    r.ctrl.lsu_we   = 1'(rand_bits(1));
    r.ctrl.lsu_addr = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    // Branches use the compare ops only
    if (kind == KIND_BRANCH) begin
      r.lane.op = alu_op_e'(4'(7 + rand_bits(2)));
    end else begin
      r.lane.op = alu_op_e'(4'(rand_bits(4) % 11));
    end
    r.lane.op_a = rand_bits(XLEN);
    r.lane.op_b = rand_bits(XLEN);
    r.lane.op_c = rand_bits(XLEN);
    // Equal operands half the time so EQ and NE both show up
    if (rand_bits(1) != 0) begin
      r.lane.op_b = r.lane.op_a;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic alu_out_t model_alu(input ex_lane_t l);
    alu_out_t o;
    o = '0;
    case (l.op)
      ALU_ADD:  o.result = l.op_a + l.op_b;
      ALU_SUB:  o.result = l.op_a - l.op_b;
      ALU_AND:  o.result = l.op_a & l.op_b;
      ALU_OR:   o.result = l.op_a | l.op_b;
      ALU_XOR:  o.result = l.op_a ^ l.op_b;
      ALU_SLL:  o.result = l.op_a << l.op_b[4:0];
      ALU_SRL:  o.result = l.op_a >> l.op_b[4:0];
      ALU_SLT: begin
        o.cmp    = $signed(l.op_a) < $signed(l.op_b);
        o.result = XLEN'(o.cmp);
      end
      ALU_SLTU: begin
        o.cmp    = l.op_a < l.op_b;
        o.result = XLEN'(o.cmp);
      end
      ALU_EQ:   o.cmp = (l.op_a == l.op_b);
      ALU_NE:   o.cmp = (l.op_a != l.op_b);
      default: ;
    endcase
    return o;
  endfunction

  function automatic logic [63:0] maj3(input logic [63:0] a, b, c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  function automatic logic [2:0] lane_errs(input logic [63:0] a, b, c, v);
    return {c != v, b != v, a != v};
  endfunction

  function automatic ft_flags_t flags_of(input logic [2:0] err);
    ft_flags_t f;
    f.detected  = (err != 3'b000);
    f.corrected = ($countones(err) == 1);
    return f;
  endfunction

  task automatic compute_model();
    logic [63:0] c [NUM_LANES];
    logic [63:0] o [NUM_LANES];
    logic [63:0] cv;
    logic [63:0] ov;
    logic [63:0] jv;
    for (int i = 0; i < NUM_LANES; i++) begin
      c[i] = 64'(req[i].ctrl);
      o[i] = 64'(model_alu(req[i].lane));
    end
    cv             = maj3(c[0], c[1], c[2]);
    ov             = maj3(o[0], o[1], o[2]);
    exp_ctrl       = cv[$bits(ex_ctrl_t)-1:0];
    exp_alu        = ov[$bits(alu_out_t)-1:0];
    exp_alu_err    = lane_errs(o[0], o[1], o[2], ov);
    exp_ctrl_flags = flags_of(lane_errs(c[0], c[1], c[2], cv));
    exp_alu_flags  = flags_of(exp_alu_err);
    // Jump target is the majority of operand c, lane 0 when all agree
    jv     = maj3(64'(req[0].lane.op_c), 64'(req[1].lane.op_c), 64'(req[2].lane.op_c));
    exp_jt = jv[XLEN-1:0];
    exp_fw.we   = exp_ctrl.fw_we;
    exp_fw.addr = exp_ctrl.fw_addr;
    if (exp_ctrl.kind == KIND_CSR) begin
      exp_fw.data = csr_rdata;
    end else if (exp_ctrl.kind == KIND_ALU) begin
      exp_fw.data = exp_alu.result;
    end else begin
      exp_fw.data = '0;
    end
    exp_valid = (exp_ctrl.kind inside {KIND_ALU, KIND_CSR, KIND_LSU}) && lsu_ready && wb_ready;
    exp_ready = (lsu_ready && wb_ready) || (exp_ctrl.kind == KIND_BRANCH);
  endtask

  // Register part of the model, called on the rising edge
  task automatic update_model();
    logic hit;
    compute_model();
    if (exp_valid) begin
      exp_wb_we = exp_ctrl.lsu_we & ~lsu_err;
      if (exp_wb_we) begin
        exp_wb_addr = exp_ctrl.lsu_addr;
      end
    end else if (wb_ready) begin
      exp_wb_we = 1'b0;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      hit = 1'b0;
      if ((exp_ctrl.kind inside {KIND_ALU, KIND_BRANCH}) && exp_alu_err[i]
          && fault_cnt[i] < THRESHOLD) begin
        fault_cnt[i]++;
        if (fault_cnt[i] == THRESHOLD) begin
          hit         = 1'b1;
          exp_perm[i] = 1'b1;
        end
      end
      exp_perf[i] = hit;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////

  task automatic expect_eq(input string sig, input logic [63:0] exp_v, input logic [63:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      $display("Mismatch %s %s: expected %0h actual %0h", test_name, sig, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_outputs();
    wb_port_t exp_wb;
    compute_model();
    exp_wb.we   = exp_wb_we;
    exp_wb.addr = exp_wb_addr;
    // Load data passes straight through in the WB cycle
    exp_wb.data = lsu_rdata;
    expect_eq("fw_o", exp_fw, fw);
    expect_eq("wb_o", exp_wb, wb);
    expect_eq("branch_decision_o", exp_alu.cmp, branch_decision);
    expect_eq("jump_target_o", exp_jt, jump_target);
    expect_eq("ex_valid_o", exp_valid, ex_valid);
    expect_eq("ex_ready_o", exp_ready, ex_ready);
    expect_eq("ctrl_flags_o", exp_ctrl_flags, ctrl_flags);
    expect_eq("alu_flags_o", exp_alu_flags, alu_flags);
    expect_eq("perm_faulty_o", exp_perm, perm_faulty);
    expect_eq("perf_faulty_o", exp_perf, perf_faulty);
  endtask

  task automatic drive_next();
    req       <= nxt_req;
    csr_rdata <= nxt_csr;
    lsu_rdata <= nxt_rdata;
    lsu_ready <= nxt_lsu_ready;
    lsu_err   <= nxt_lsu_err;
    wb_ready  <= nxt_wb_ready;
  endtask

  // Model sees the inputs of the closing cycle before new ones land
  task automatic step();
    @(posedge clk);
    update_model();
    drive_next();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic fill_lanes(input ex_req_t r);
    for (int i = 0; i < NUM_LANES; i++) begin
      nxt_req[i] = r;
    end
  endtask

  task automatic set_idle();
    fill_lanes('0);
    nxt_csr       = '0;
    nxt_rdata     = '0;
    nxt_lsu_ready = 1'b1;
    nxt_lsu_err   = 1'b0;
    nxt_wb_ready  = 1'b1;
  endtask

  task automatic rand_side();
    nxt_csr       = rand_bits(XLEN);
    nxt_rdata     = rand_bits(XLEN);
    nxt_lsu_ready = 1'(rand_bits(1));
    nxt_lsu_err   = 1'(rand_bits(1));
    nxt_wb_ready  = 1'(rand_bits(1));
  endtask

  // Reset held low across three rising edges
  task automatic apply_reset();
    set_idle();
    @(posedge clk);
    rst_n <= 1'b0;
    drive_next();
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
    end
    rst_n       <= 1'b1;
    exp_wb_we   = 1'b0;
    exp_wb_addr = '0;
    exp_perm    = '0;
    exp_perf    = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      fault_cnt[i] = 0;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    apply_reset();
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d errors", test_name, test_errors);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    ex_req_t     r;
    alu_out_t    ref_out;
    logic [31:0] m1;
    logic [31:0] m2;
    int          k;
    int          pulses;
    int          waited;
    logic        accepted;
    logic        acc_we;
    logic        ctrl_hit;

    rst_n        = 1'b0;
    req          = '0;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    lsu_ready    = 1'b1;
    lsu_err      = 1'b0;
    wb_ready     = 1'b1;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;

    // Clean lanes, ALU and CSR forwarding
    begin_test("clean_alu_csr");
    for (int n = 0; n < N_ITER; n++) begin
      fill_lanes(rand_req((rand_bits(1) != 0) ? KIND_CSR : KIND_ALU));
      rand_side();
      step();
      expect_eq("ctrl_flags_o clean", 2'b00, ctrl_flags);
      expect_eq("alu_flags_o clean", 2'b00, alu_flags);
    end
    end_test();

    // One bad lane, either operands or control
    begin_test("single_lane_fault");
    for (int n = 0; n < N_ITER; n++) begin
      r         = rand_req(KIND_ALU);
      r.lane.op = pick_arith();
      fill_lanes(r);
      rand_side();
      k        = int'(rand_bits(2) % 3);
      m1       = rand_bits(32) | 32'h1;
      ctrl_hit = (rand_bits(1) == 0);
      if (!ctrl_hit) begin
        nxt_req[k].lane.op_a ^= m1;
        nxt_req[k].lane.op_c ^= m1;
      end else begin
        nxt_req[k].ctrl.fw_addr ^= REG_ADDR_W'(m1);
      end
      step();
      ref_out = model_alu(r.lane);
      expect_eq("fw_o fault free", {r.ctrl.fw_we, r.ctrl.fw_addr, ref_out.result}, fw);
      expect_eq("jump_target_o fault free", r.lane.op_c, jump_target);
      expect_eq("ctrl_flags_o corrected", ctrl_hit ? 2'b11 : 2'b00, ctrl_flags);
      expect_eq("alu_flags_o corrected", ctrl_hit ? 2'b00 : 2'b11, alu_flags);
    end
    end_test();

    // Two bad lanes with different corruption
    begin_test("double_lane_fault");
    for (int n = 0; n < N_ITER; n++) begin
      r         = rand_req(KIND_ALU);
      r.lane.op = pick_arith();
      fill_lanes(r);
      rand_side();
      k  = int'(rand_bits(2) % 3);
      m1 = {1'b0, 30'(rand_bits(30)), 1'b1};
      m2 = ~m1;
      nxt_req[(k + 1) % 3].lane.op_a ^= m1;
      nxt_req[(k + 2) % 3].lane.op_a ^= m2;
      step();
      expect_eq("alu_flags_o uncorrected", 2'b10, alu_flags);
    end
    end_test();

    // Lane 1 keeps failing until it is marked permanent
    begin_test("perm_fault_lane1");
    pulses = 0;
    for (int n = 0; n < THRESHOLD + 4; n++) begin
      r         = rand_req(KIND_ALU);
      r.lane.op = pick_arith();
      fill_lanes(r);
      rand_side();
      // Last two requests are clean
      if (n < THRESHOLD + 2) begin
        nxt_req[1].lane.op_a ^= rand_bits(32) | 32'h1;
      end
      step();
      if (perf_faulty[1]) begin
        pulses++;
      end
    end
    expect_eq("perf_faulty_o[1] pulses", 1, pulses);
    expect_eq("perm_faulty_o[1] sticky", 1'b1, perm_faulty[1]);
    end_test();

    // Branches retire in EX regardless of WB
    begin_test("branch");
    for (int n = 0; n < N_ITER; n++) begin
      r = rand_req(KIND_BRANCH);
      fill_lanes(r);
      rand_side();
      step();
      ref_out = model_alu(r.lane);
      expect_eq("branch_decision_o", ref_out.cmp, branch_decision);
      expect_eq("jump_target_o op_c", r.lane.op_c, jump_target);
      expect_eq("ex_ready_o branch", 1'b1, ex_ready);
      expect_eq("ex_valid_o branch", 1'b0, ex_valid);
    end
    end_test();

    // LSU write-back through the EX/WB register
    begin_test("lsu_writeback");
    for (int n = 0; n < N_ITER / 2; n++) begin
      r = rand_req(KIND_LSU);
      fill_lanes(r);
      accepted = 1'b0;
      for (waited = 0; waited < WAIT_LIMIT && !accepted; waited++) begin
        rand_side();
        step();
        accepted = ex_valid;
      end
      assert (accepted) else begin
        $display("Timeout in %s: ex_valid_o stayed low for %0d cycles", test_name, WAIT_LIMIT);
        test_errors++;
      end
      acc_we = r.ctrl.lsu_we & ~lsu_err;
      // Accepting edge, WB stalled in the same cycle
      set_idle();
      nxt_rdata    = rand_bits(XLEN);
      nxt_wb_ready = 1'b0;
      step();
      expect_eq("wb_o.we loaded", acc_we, wb.we);
      if (acc_we) begin
        expect_eq("wb_o.addr loaded", r.ctrl.lsu_addr, wb.addr);
      end
      // Stalled edge holds, then an idle edge with WB ready clears
      nxt_wb_ready = 1'b1;
      step();
      expect_eq("wb_o.we held", acc_we, wb.we);
      step();
      expect_eq("wb_o.we cleared", 1'b0, wb.we);
    end
    end_test();

    $display("%0d tests run, %0d with errors, %0d checks", tests_run, tests_failed, checks);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/ex_ft_pkg.sv
logic/ft_majority_voter.sv
logic/ex_alu.sv
logic/ex_decode.sv
logic/ex_execute.sv
logic/ex_result.sv
logic/ex_stage_ft.sv
tb/tb_ex_stage_ft.sv

// ==== Makefile ====
# Verilator flow for the fault-tolerant execute stage

VERILATOR ?= verilator
TOP       ?= tb_ex_stage_ft
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^all tests passed$$' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
